// File: router_out_patterns.hex
// each record is 12 hex digits: phase, input port, channel, a zero pad digit, then the flit
// flit bits 31:30 type, 29:22 size on a head, 21:20 source port, 19:0 sequence number
100000000001
110000100001
120000200001
130000300001
200000800010
200040000011
200080000012
201000400013
201080000014
211000500010
211080100011
210000900012
210040100013
210080100014
220000a00010
220040200011
220080200012
221000600013
221080200014
231000700010
231080300011
230000b00012
230040300013
230080300014
301000400020
301080000021
310000500020
310080100021
420001200030
420040200031
420040200032
420040200033
420080200034

// File: compile.f
noc_cfg_pkg.sv
noc_flit_pkg.sv
rr_arbiter.sv
flit_buffer.sv
output_module.sv
router_out_top.sv
tb_clk_gen.sv
tb_router_out.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile the router output port and its testbench with Verilator, then run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps --top-module tb_router_out -f compile.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_router_out 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "^SIMULATION PASSED$"; then
  exit 0
fi
echo "pass message not found in the simulation output"
exit 1

// File: tb_router_out.sv
`timescale 1ns/100ps

module tb_router_out
  import noc_cfg_pkg::*;
  import noc_flit_pkg::*;
();

  localparam int          BUF_DEPTH   = 4;
  localparam prio_order_t H_PRIO      = ZERO_HIGH_PRIOR;
  localparam int          N_RECORDS   = 33;
  localparam int          TIMEOUT_CYC = 500;
  // the payload carries the sending port in these two bits
  localparam int          SRC_LSB     = 20;

  logic                                  clk;
  logic                                  arst_n;
  logic [N_IN_PORTS-1:0]                 in_valid;
  logic [N_IN_PORTS-1:0]                 in_ready;
  logic [N_IN_PORTS-1:0][FLIT_WIDTH-1:0] in_flit;
  logic [N_IN_PORTS-1:0][VC_WIDTH-1:0]   in_vc;
  logic                                  out_valid;
  logic                                  out_ready;
  logic [FLIT_WIDTH-1:0]                 out_flit;
  logic [VC_WIDTH-1:0]                   out_vc;

  // records as read from the pattern file
  logic [47:0]                    pat_mem [N_RECORDS];
  // indices of the records that belong to the phase being run
  int                             rec_idx [$];
  // expected output in order with each entry holding {channel, flit}
  logic [VC_WIDTH+FLIT_WIDTH-1:0] seq_exp [$];
  // expected flits per source and channel, where only their own order is fixed
  logic [FLIT_WIDTH-1:0]          stream_exp [N_IN_PORTS*N_VIRT_CHN][$];
  // source and remaining flits of the packet that is open on each output channel
  int                             open_src [N_VIRT_CHN];
  int                             open_len [N_VIRT_CHN];
  bit                             strict_order;
  integer                         seed;

  tb_clk_gen #(
    .PERIOD_NS (4.0)
  ) u_clk_gen (
    .clk_o (clk)
  );

  router_out_top #(
    .BUF_DEPTH  (BUF_DEPTH),
    .H_PRIORITY (H_PRIO)
  ) dut (
    .clk         (clk),
    .arst_n_i    (arst_n),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .in_flit_i   (in_flit),
    .in_vc_i     (in_vc),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready),
    .out_flit_o  (out_flit),
    .out_vc_o    (out_vc)
  );

  // record layout is phase, port, channel, a pad digit and the flit
  function automatic int rec_phase(input int i);
    return int'(pat_mem[i][47:44]);
  endfunction

  function automatic int rec_port(input int i);
    return int'(pat_mem[i][43:40]);
  endfunction

  function automatic logic [VC_WIDTH-1:0] rec_vc(input int i);
    return pat_mem[i][36 +: VC_WIDTH];
  endfunction

  function automatic logic [FLIT_WIDTH-1:0] rec_flit(input int i);
    return pat_mem[i][FLIT_WIDTH-1:0];
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped after an error");
  endtask

  task automatic check_eq(input string name, input logic [63:0] actual,
                          input logic [63:0] expected);
    if (actual !== expected) begin
      $display("MISMATCH time=%0t signal=%s actual=%0h expected=%0h",
               $time, name, actual, expected);
      fail_run("stopping at the first wrong value");
    end
  endtask

  // gather the records of one phase in file order
  task automatic select_phase(input int phase);
    rec_idx.delete();
    for (int i = 0; i < N_RECORDS; i++) begin
      if (rec_phase(i) == phase) begin
        rec_idx.push_back(i);
      end
    end
  endtask

  // starts on a falling edge and returns on the falling edge after the flit was taken
  task automatic send_flit(input int port, input logic [VC_WIDTH-1:0] vc,
                           input logic [FLIT_WIDTH-1:0] flit);
    int waited;
    waited = 0;
    in_valid[port] = 1'b1;
    in_flit[port]  = flit;
    in_vc[port]    = vc;
    // in_ready only moves on a rising edge, so the value seen here holds until the next one
    while (!in_ready[port]) begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT_CYC) begin
        fail_run($sformatf("timeout: input port %0d never accepted its flit", port));
      end
    end
    @(negedge clk);
    in_valid[port] = 1'b0;
  endtask

  task automatic load_records(input int first, input int last);
    for (int k = first; k < last; k++) begin
      send_flit(rec_port(rec_idx[k]), rec_vc(rec_idx[k]), rec_flit(rec_idx[k]));
    end
  endtask

  task automatic drive_port(input int port);
    foreach (rec_idx[k]) begin
      if (rec_port(rec_idx[k]) == port) begin
        send_flit(port, rec_vc(rec_idx[k]), rec_flit(rec_idx[k]));
      end
    end
  endtask

  task automatic check_output();
    logic [VC_WIDTH+FLIT_WIDTH-1:0] exp_word;
    int                             src;
    int                             vc;
    int                             key;
    src = int'(out_flit[SRC_LSB +: 2]);
    vc  = int'(out_vc);
    key = src * N_VIRT_CHN + vc;
    if (strict_order) begin
      if (seq_exp.size() == 0) begin
        fail_run("a flit left the router when none was expected");
      end else begin
        exp_word = seq_exp.pop_front();
        check_eq("out_flit_o", 64'(out_flit), 64'(exp_word[FLIT_WIDTH-1:0]));
        check_eq("out_vc_o", 64'(out_vc), 64'(exp_word[FLIT_WIDTH +: VC_WIDTH]));
      end
    end else if (stream_exp[key].size() == 0) begin
      fail_run($sformatf("unexpected flit from port %0d on channel %0d", src, vc));
    end else begin
      check_eq("out_flit_o", 64'(out_flit), 64'(stream_exp[key].pop_front()));
      // a packet that started on this channel must finish before another source shows up
      if (open_len[vc] > 0) begin
        check_eq("out_flit_o source", 64'(src), 64'(open_src[vc]));
        open_len[vc]--;
      end else if (out_flit[TYPE_MSB:TYPE_LSB] == HEAD_FLIT) begin
        open_src[vc] = src;
        open_len[vc] = int'(out_flit[SIZE_MSB:SIZE_LSB]);
      end
    end
  endtask

  task automatic drain_output(input int n_flits, input bit rand_ready);
    int got;
    int idle;
    int rnd;
    got  = 0;
    idle = 0;
    while (got < n_flits) begin
      @(negedge clk);
      if (rand_ready) begin
        rnd       = $random(seed);
        out_ready = rnd[0];
      end else begin
        out_ready = 1'b1;
      end
      // out_valid and out_flit settle after the rising edge and the transfer is on the next one
      if (out_valid && out_ready) begin
        check_output();
        got++;
        idle = 0;
      end else begin
        idle++;
        if (idle > TIMEOUT_CYC) begin
          fail_run($sformatf("timeout: only %0d of %0d flits left the router", got, n_flits));
        end
      end
    end
    @(negedge clk);
    out_ready = 1'b0;
    check_eq("out_valid_o", 64'(out_valid), 64'(0));
  endtask

  initial begin
    int port4;
    int v;
    arst_n       = 1'b0;
    in_valid     = '0;
    in_flit      = '0;
    in_vc        = '0;
    out_ready    = 1'b0;
    seed         = 32'h8c13;
    strict_order = 1'b1;
    open_src     = '{default: 0};
    open_len     = '{default: 0};
    $readmemh("router_out_patterns.hex", pat_mem);
    repeat (16) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    // after reset the buffers are empty and all accept
    @(negedge clk);
    check_eq("out_valid_o", 64'(out_valid), 64'(0));
    check_eq("in_ready_o", 64'(in_ready), 64'({N_IN_PORTS{1'b1}}));

    // the channel 0 pointer starts at input 0 and steps one past each winner
    select_phase(1);
    for (int p = 0; p < N_IN_PORTS; p++) begin
      foreach (rec_idx[k]) begin
        if (rec_port(rec_idx[k]) == p) begin
          seq_exp.push_back({rec_vc(rec_idx[k]), rec_flit(rec_idx[k])});
        end
      end
    end
    load_records(0, rec_idx.size());
    drain_output(rec_idx.size(), 1'b0);

    // all ports on both channels while the output link stalls at random
    strict_order = 1'b0;
    select_phase(2);
    foreach (rec_idx[k]) begin
      v = rec_port(rec_idx[k]) * N_VIRT_CHN + int'(rec_vc(rec_idx[k]));
      stream_exp[v].push_back(rec_flit(rec_idx[k]));
    end
    fork
      drive_port(0);
      drive_port(1);
      drive_port(2);
      drive_port(3);
      drain_output(rec_idx.size(), 1'b1);
    join

    // with both channels loaded the higher priority channel drains first
    strict_order = 1'b1;
    select_phase(3);
    for (int k = 0; k < N_VIRT_CHN; k++) begin
      v = (H_PRIO == ZERO_HIGH_PRIOR) ? k : N_VIRT_CHN - 1 - k;
      foreach (rec_idx[j]) begin
        if (rec_vc(rec_idx[j]) == VC_WIDTH'(v)) begin
          seq_exp.push_back({rec_vc(rec_idx[j]), rec_flit(rec_idx[j])});
        end
      end
    end
    load_records(0, rec_idx.size());
    drain_output(rec_idx.size(), 1'b0);

    // one port fed past its depth while the link is stalled
    select_phase(4);
    foreach (rec_idx[k]) begin
      seq_exp.push_back({rec_vc(rec_idx[k]), rec_flit(rec_idx[k])});
    end
    load_records(0, BUF_DEPTH);
    port4 = rec_port(rec_idx[BUF_DEPTH]);
    check_eq("in_ready_o", 64'(in_ready[port4]), 64'(0));
    fork
      send_flit(port4, rec_vc(rec_idx[BUF_DEPTH]), rec_flit(rec_idx[BUF_DEPTH]));
      begin
        // the stalled link keeps showing the head flit of the packet
        repeat (8) begin
          @(negedge clk);
          check_eq("out_valid_o", 64'(out_valid), 64'(1));
          check_eq("out_flit_o", 64'(out_flit), 64'(rec_flit(rec_idx[0])));
          check_eq("out_vc_o", 64'(out_vc), 64'(rec_vc(rec_idx[0])));
        end
        drain_output(rec_idx.size(), 1'b0);
      end
    join

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter real PERIOD_NS = 4.0
) (
  output logic clk_o
);

  // free running clock that starts low, so the first rising edge comes after half a period
  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end
  end

endmodule

// File: router_out_top.sv
`timescale 1ns/100ps

module router_out_top import noc_cfg_pkg::*; import noc_flit_pkg::*; #(
  parameter int          BUF_DEPTH  = 4,
  parameter prio_order_t H_PRIORITY = ZERO_HIGH_PRIOR
) (
  input  logic                                  clk,
  input  logic                                  arst_n_i,
  // the four input links
  input  logic [N_IN_PORTS-1:0]                 in_valid_i,
  output logic [N_IN_PORTS-1:0]                 in_ready_o,
  input  logic [N_IN_PORTS-1:0][FLIT_WIDTH-1:0] in_flit_i,
  input  logic [N_IN_PORTS-1:0][VC_WIDTH-1:0]   in_vc_i,
  // the shared output link
  output logic                                  out_valid_o,
  input  logic                                  out_ready_i,
  output logic [FLIT_WIDTH-1:0]                 out_flit_o,
  output logic [VC_WIDTH-1:0]                   out_vc_o
);

  // buffer heads as seen by the output arbitration
  logic [N_IN_PORTS-1:0]                 buf_valid;
  logic [N_IN_PORTS-1:0][FLIT_WIDTH-1:0] buf_flit;
  logic [N_IN_PORTS-1:0][VC_WIDTH-1:0]   buf_vc;
  logic [N_IN_PORTS-1:0]                 buf_ready;

  // each input link gets its own small queue
  for (genvar p = 0; p < N_IN_PORTS; p++) begin : g_in_buf
    flit_buffer #(
      .BUF_DEPTH (BUF_DEPTH)
    ) u_flit_buffer (
      .clk        (clk),
      .arst_n_i   (arst_n_i),
      .wr_valid_i (in_valid_i[p]),
      .wr_flit_i  (in_flit_i[p]),
      .wr_vc_i    (in_vc_i[p]),
      .wr_ready_o (in_ready_o[p]),
      .rd_valid_o (buf_valid[p]),
      .rd_flit_o  (buf_flit[p]),
      .rd_vc_o    (buf_vc[p]),
      .rd_ready_i (buf_ready[p])
    );
  end

  // arbitration and output mux drive the link with no register stage on the way out
  output_module #(
    .H_PRIORITY (H_PRIORITY)
  ) u_output_module (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .fin_valid_i  (buf_valid),
    .fin_flit_i   (buf_flit),
    .fin_vc_i     (buf_vc),
    .fin_ready_o  (buf_ready),
    .fout_valid_o (out_valid_o),
    .fout_flit_o  (out_flit_o),
    .fout_vc_o    (out_vc_o),
    .fout_ready_i (out_ready_i)
  );

endmodule

// File: output_module.sv
`timescale 1ns/100ps

module output_module import noc_cfg_pkg::*; import noc_flit_pkg::*; #(
  parameter prio_order_t H_PRIORITY = ZERO_HIGH_PRIOR
) (
  input  logic                                  clk,
  input  logic                                  arst_n_i,
  // flits at the head of each input buffer
  input  logic [N_IN_PORTS-1:0]                 fin_valid_i,
  input  logic [N_IN_PORTS-1:0][FLIT_WIDTH-1:0] fin_flit_i,
  input  logic [N_IN_PORTS-1:0][VC_WIDTH-1:0]   fin_vc_i,
  output logic [N_IN_PORTS-1:0]                 fin_ready_o,
  // the outgoing link of this port
  output logic                                  fout_valid_o,
  output logic [FLIT_WIDTH-1:0]                 fout_flit_o,
  output logic [VC_WIDTH-1:0]                   fout_vc_o,
  input  logic                                  fout_ready_i
);

  localparam int PORT_W = (N_IN_PORTS > 1) ? $clog2(N_IN_PORTS) : 1;

  logic [N_VIRT_CHN-1:0][N_IN_PORTS-1:0] req_vc;
  logic [N_VIRT_CHN-1:0][N_IN_PORTS-1:0] grant_vc;
  logic [N_VIRT_CHN-1:0]                 update_vc;
  // channels whose winner has a flit waiting right now
  logic [N_VIRT_CHN-1:0]                 chn_rdy;
  logic [VC_WIDTH-1:0]                   act_vc;
  logic                                  act_found;
  logic [PORT_W-1:0]                     sel_port;
  flit_type_t                            out_type;
  logic                                  pkt_end;

  // sort the buffer heads by the channel they travel on
  always_comb begin
    req_vc = '0;
    for (int v = 0; v < N_VIRT_CHN; v++) begin
      for (int p = 0; p < N_IN_PORTS; p++) begin
        req_vc[v][p] = fin_valid_i[p] && (fin_vc_i[p] == VC_WIDTH'(v));
      end
    end
  end

  // one round robin arbiter per channel, each one locks onto a packet
  for (genvar v = 0; v < N_VIRT_CHN; v++) begin : g_vc_arb
    rr_arbiter #(
      .N_OF_INPUTS (N_IN_PORTS)
    ) u_rr_arbiter (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .req_i    (req_vc[v]),
      .update_i (update_vc[v]),
      .grant_o  (grant_vc[v])
    );
    // a locked owner whose buffer ran dry does not block the other channels
    assign chn_rdy[v] = |(grant_vc[v] & fin_valid_i);
  end

  // fixed priority between the channels, direction set by the top level
  always_comb begin
    act_vc    = '0;
    act_found = 1'b0;
    if (H_PRIORITY == ZERO_HIGH_PRIOR) begin
      for (int v = 0; v < N_VIRT_CHN; v++) begin
        if (!act_found && chn_rdy[v]) begin
          act_vc    = VC_WIDTH'(v);
          act_found = 1'b1;
        end
      end
    end else begin
      for (int v = N_VIRT_CHN - 1; v >= 0; v--) begin
        if (!act_found && chn_rdy[v]) begin
          act_vc    = VC_WIDTH'(v);
          act_found = 1'b1;
        end
      end
    end
  end

  // turn the one-hot grant of the active channel into a port number
  always_comb begin
    sel_port = '0;
    for (int p = 0; p < N_IN_PORTS; p++) begin
      if (grant_vc[act_vc][p]) begin
        sel_port = PORT_W'(p);
      end
    end
  end

  assign fout_valid_o = act_found;
  assign fout_flit_o  = fin_flit_i[sel_port];
  assign fout_vc_o    = act_vc;

  // only the forwarded input sees the link's ready
  always_comb begin
    fin_ready_o = '0;
    if (act_found) begin
      fin_ready_o[sel_port] = fout_ready_i;
    end
  end

  // a tail flit or a head with size zero closes the packet
  assign out_type = flit_type_t'(fout_flit_o[TYPE_MSB:TYPE_LSB]);
  assign pkt_end  = (out_type == TAIL_FLIT) ||
                    ((out_type == HEAD_FLIT) &&
                     (fout_flit_o[SIZE_MSB:SIZE_LSB] == MIN_SIZE_FLIT));

  // release the arbiter of the active channel once its last flit is taken
  always_comb begin
    update_vc = '0;
    update_vc[act_vc] = fout_valid_o && fout_ready_i && pkt_end;
  end

endmodule

// File: flit_buffer.sv
`timescale 1ns/100ps

module flit_buffer import noc_cfg_pkg::*; import noc_flit_pkg::*; #(
  parameter int BUF_DEPTH = 4
) (
  input  logic                  clk,
  input  logic                  arst_n_i,
  // write side, from the input link
  input  logic                  wr_valid_i,
  input  logic [FLIT_WIDTH-1:0] wr_flit_i,
  input  logic [VC_WIDTH-1:0]   wr_vc_i,
  output logic                  wr_ready_o,
  // read side, towards the output arbitration
  output logic                  rd_valid_o,
  output logic [FLIT_WIDTH-1:0] rd_flit_o,
  output logic [VC_WIDTH-1:0]   rd_vc_o,
  input  logic                  rd_ready_i
);

  localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
  localparam int CNT_W = $clog2(BUF_DEPTH + 1);

  // each entry keeps the flit next to the channel it travels on
  logic [FLIT_WIDTH-1:0] flit_mem [BUF_DEPTH];
  logic [VC_WIDTH-1:0]   vc_mem   [BUF_DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  // ready is low only when every entry is taken
  assign wr_ready_o = (count_q != CNT_W'(BUF_DEPTH));
  assign rd_valid_o = (count_q != '0);

  // the oldest entry is always on the read side
  assign rd_flit_o = flit_mem[rd_ptr_q];
  assign rd_vc_o   = vc_mem[rd_ptr_q];

  assign push = wr_valid_i & wr_ready_o;
  assign pop  = rd_valid_o & rd_ready_i;

  always_ff @(posedge clk) begin
    if (push) begin
      flit_mem[wr_ptr_q] <= wr_flit_i;
      vc_mem[wr_ptr_q]   <= wr_vc_i;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // pointers wrap by hand so that depths other than powers of two also work
      if (push) begin
        wr_ptr_q <= (int'(wr_ptr_q) == BUF_DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (int'(rd_ptr_q) == BUF_DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      // a push and a pop in one cycle leave the count as it is
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

// File: rr_arbiter.sv
`timescale 1ns/100ps

module rr_arbiter #(
  parameter int N_OF_INPUTS = 4
) (
  input  logic                   clk,
  input  logic                   arst_n_i,
  input  logic [N_OF_INPUTS-1:0] req_i,
  input  logic                   update_i,
  output logic [N_OF_INPUTS-1:0] grant_o
);

  localparam int IDX_W = (N_OF_INPUTS > 1) ? $clog2(N_OF_INPUTS) : 1;

  // pointer to the input that is looked at first when the arbiter is free
  logic [IDX_W-1:0] ptr_q;
  // set while a packet owns the arbiter
  logic             locked_q;
  logic [IDX_W-1:0] lock_idx_q;

  // first requester found at or after the pointer
  logic [IDX_W-1:0] found_idx;
  logic             found;
  // input that holds the grant in this cycle
  logic [IDX_W-1:0] cur_idx;
  logic             cur_grant;

  // rotating search over the requests, starting at the pointer
  always_comb begin : search_req
    int idx;
    found_idx = '0;
    found     = 1'b0;
    for (int i = 0; i < N_OF_INPUTS; i++) begin
      idx = int'(ptr_q) + i;
      if (idx >= N_OF_INPUTS) begin
        idx = idx - N_OF_INPUTS;
      end
      if (!found && req_i[idx]) begin
        found_idx = IDX_W'(idx);
        found     = 1'b1;
      end
    end
  end

  // a locked arbiter keeps its owner even when the request goes away
  assign cur_idx   = locked_q ? lock_idx_q : found_idx;
  assign cur_grant = locked_q | found;

  always_comb begin
    grant_o = '0;
    if (cur_grant) begin
      grant_o[cur_idx] = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_q      <= '0;
      locked_q   <= 1'b0;
      lock_idx_q <= '0;
    end else if (update_i) begin
      // the packet has left, so release and move one past the winner
      locked_q <= 1'b0;
      if (int'(cur_idx) == N_OF_INPUTS - 1) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= cur_idx + 1'b1;
      end
    end else if (!locked_q && found) begin
      // hold the new winner until its last flit is through
      locked_q   <= 1'b1;
      lock_idx_q <= found_idx;
    end
  end

endmodule

// File: noc_flit_pkg.sv
package noc_flit_pkg;

  // every flit on the mesh links is one 32 bit word
  localparam int FLIT_WIDTH = 32;

  // the flit type lives in the two top bits of every flit
  localparam int TYPE_MSB   = FLIT_WIDTH - 1;
  localparam int TYPE_LSB   = FLIT_WIDTH - 2;
  localparam int TYPE_WIDTH = TYPE_MSB - TYPE_LSB + 1;

  typedef enum logic [TYPE_WIDTH-1:0] {
    HEAD_FLIT = 2'b00,
    BODY_FLIT = 2'b01,
    TAIL_FLIT = 2'b10
  } flit_type_t;

  // a head flit carries the packet size right below the type field
  // the size counts only the flits that follow the head
  localparam int SIZE_MSB   = TYPE_LSB - 1;
  localparam int SIZE_LSB   = TYPE_LSB - 8;
  localparam int SIZE_WIDTH = SIZE_MSB - SIZE_LSB + 1;

  // a size of zero means the head flit is the whole packet
  localparam logic [SIZE_WIDTH-1:0] MIN_SIZE_FLIT = '0;

  // the remaining low bits below SIZE_LSB are payload and are never decoded here

endpackage

// File: noc_cfg_pkg.sv
package noc_cfg_pkg;

  // number of virtual channels sharing the outgoing link
  localparam int N_VIRT_CHN = 2;

  // width of a virtual channel number, kept at one bit even for a single channel
  localparam int VC_WIDTH = (N_VIRT_CHN > 1) ? $clog2(N_VIRT_CHN) : 1;

  // input ports that compete for this output port of the router
  localparam int N_IN_PORTS = 4;

  // order in which the virtual channels get the link
  // with ZERO_HIGH_PRIOR channel 0 beats every higher channel
  // with ZERO_LOW_PRIOR the highest numbered channel wins instead
  typedef enum logic {
    ZERO_HIGH_PRIOR = 1'b0,
    ZERO_LOW_PRIOR  = 1'b1
  } prio_order_t;

endpackage
